// ==== logic/ccc_pkg.sv ====
// CCC handler shared definitions
`default_nettype none

package ccc_pkg;

  // Bus and register widths
  localparam int ADDR_W = 7;
  localparam int BYTE_W = 8;
  localparam int LEN_W  = 16;
  localparam int PID_W  = 48;

  // Reserved broadcast address
  localparam logic [ADDR_W-1:0] RSVD_ADDR = 7'h7E;

  // Longest direct GET response in bytes
  localparam int MAX_GET_BYTES = 6;
  localparam int CNT_W         = $clog2(MAX_GET_BYTES + 1);

  // Max IBI payload byte sent last in GETMRL
  localparam logic [BYTE_W-1:0] MRL_IBI_BYTE = 8'hFF;

  // Supported command codes, bit 7 set for direct commands
  typedef enum logic [7:0] {
    ENEC_B   = 8'h00,
    DISEC_B  = 8'h01,
    RSTDAA   = 8'h06,
    SETMWL_B = 8'h09,
    SETMRL_B = 8'h0A,
    ENEC_D   = 8'h80,
    DISEC_D  = 8'h81,
    SETMWL_D = 8'h89,
    SETMRL_D = 8'h8A,
    GETMWL   = 8'h8B,
    GETMRL   = 8'h8C,
    GETPID   = 8'h8D,
    GETBCR   = 8'h8E,
    GETDCR   = 8'h8F
  } ccc_code_e;

  // Handler states
  typedef enum logic [4:0] {
    ST_IDLE         = 5'd0,
    ST_WAIT         = 5'd1,
    ST_RX_TBIT      = 5'd2,
    ST_RX_DATA      = 5'd3,
    ST_RX_DATA_TBIT = 5'd4,
    ST_SKIP         = 5'd5,
    ST_RX_ADDR      = 5'd6,
    ST_TX_ADDR_ACK  = 5'd7,
    ST_TX_DATA      = 5'd8,
    ST_TX_DATA_TBIT = 5'd9,
    ST_WAIT_COND    = 5'd10,
    ST_WAIT_STOP    = 5'd11,
    ST_DONE         = 5'd12
  } ccc_state_e;

endpackage

`default_nettype wire

// ==== logic/ccc_fsm.sv ====
// CCC handler state machine
`timescale 1ns/1ns
`default_nettype none

module ccc_fsm (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  ccc_pkg::ccc_code_e            ccc_i,
  input  logic                          ccc_valid_i,
  input  logic                          bus_rstart_det_i,
  input  logic                          bus_stop_det_i,
  input  logic [ccc_pkg::BYTE_W-1:0]    bus_rx_data_i,
  input  logic                          bus_rx_done_i,
  input  logic                          bus_tx_done_i,
  input  logic [ccc_pkg::ADDR_W-1:0]    target_sta_address_i,
  input  logic                          target_sta_address_valid_i,
  input  logic [ccc_pkg::ADDR_W-1:0]    target_dyn_address_i,
  input  logic                          target_dyn_address_valid_i,
  input  logic [ccc_pkg::BYTE_W-1:0]    tx_byte_i,
  input  logic                          tx_last_i,
  output logic                          done_fsm_o,
  output logic                          bus_rx_req_bit_o,
  output logic                          bus_rx_req_byte_o,
  output logic                          bus_tx_req_bit_o,
  output logic                          bus_tx_req_byte_o,
  output logic [ccc_pkg::BYTE_W-1:0]    bus_tx_req_value_o,
  output logic                          bus_tx_sel_od_pp_o,
  output ccc_pkg::ccc_code_e            code_o,
  output logic                          tx_load_o,
  output logic                          tx_next_o,
  output logic [ccc_pkg::BYTE_W-1:0]    rx_byte_o,
  output logic                          rx_byte_valid_o,
  output logic                          xfer_start_o,
  output logic                          rstdaa_event_o
);
  import ccc_pkg::*;

  ccc_state_e        state_q, state_d;
  ccc_code_e         code_q;
  logic [ADDR_W-1:0] addr_q;
  logic              rnw_q;
  logic [BYTE_W-1:0] rx_q;
  logic              is_direct;
  logic              is_get;
  logic              has_data;
  logic              addr_ours;
  logic              addr_rsvd;

  assign is_direct = code_q[7];
  assign is_get    = code_q inside {GETMWL, GETMRL, GETPID, GETBCR, GETDCR};
  // Only RSTDAA among the broadcasts comes without data
  assign has_data  = (code_q != RSTDAA);
  assign addr_rsvd = (addr_q == RSVD_ADDR);

  // Dynamic address wins over static
  always_comb begin
    if (target_dyn_address_valid_i) begin
      addr_ours = (addr_q == target_dyn_address_i);
    end else if (target_sta_address_valid_i) begin
      addr_ours = (addr_q == target_sta_address_i);
    end else begin
      addr_ours = 1'b0;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:         state_d = ST_WAIT;
      ST_WAIT:         if (ccc_valid_i) state_d = ST_RX_TBIT;
      ST_RX_TBIT: begin
        if (bus_rx_done_i) begin
          if (is_direct) state_d = ST_SKIP;
          else if (has_data) state_d = ST_RX_DATA;
          else state_d = ST_WAIT_STOP;
        end
      end
      ST_RX_DATA: begin
        if (bus_rstart_det_i) state_d = ST_RX_ADDR;
        else if (bus_rx_done_i) state_d = ST_RX_DATA_TBIT;
      end
      ST_RX_DATA_TBIT: if (bus_rx_done_i) state_d = ST_RX_DATA;
      // Anything before the first Sr of a direct CCC is dropped
      ST_SKIP:         if (bus_rstart_det_i) state_d = ST_RX_ADDR;
      ST_RX_ADDR:      if (bus_rx_done_i) state_d = ST_TX_ADDR_ACK;
      ST_TX_ADDR_ACK: begin
        if (bus_tx_done_i) begin
          if (addr_rsvd) state_d = ST_WAIT_STOP;
          else if (addr_ours && rnw_q && is_get) state_d = ST_TX_DATA;
          else if (addr_ours && !rnw_q && !is_get) state_d = ST_RX_DATA;
          else state_d = ST_WAIT_COND;
        end
      end
      ST_TX_DATA:      if (bus_tx_done_i) state_d = ST_TX_DATA_TBIT;
      ST_TX_DATA_TBIT: begin
        if (bus_tx_done_i) state_d = tx_last_i ? ST_WAIT_COND : ST_TX_DATA;
      end
      ST_WAIT_COND:    if (bus_rstart_det_i) state_d = ST_RX_ADDR;
      ST_WAIT_STOP:    state_d = ST_WAIT_STOP;
      ST_DONE:         state_d = ST_IDLE;
      default:         state_d = ST_IDLE;
    endcase
  end

  // STOP ends the flow from any state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else if (bus_stop_det_i) begin
      state_q <= ST_DONE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      code_q <= ccc_code_e'(8'h00);
      addr_q <= '0;
      rnw_q  <= 1'b0;
      rx_q   <= '0;
    end else begin
      if (state_q == ST_WAIT && ccc_valid_i) begin
        code_q <= ccc_i;
        addr_q <= '0;
        rnw_q  <= 1'b0;
      end
      if (state_q == ST_RX_ADDR && bus_rx_done_i) begin
        addr_q <= bus_rx_data_i[BYTE_W-1:1];
        rnw_q  <= bus_rx_data_i[0];
      end
      if (state_q == ST_RX_DATA && bus_rx_done_i) rx_q <= bus_rx_data_i;
    end
  end

  // Bus requests
  assign bus_rx_req_bit_o  = state_q inside {ST_RX_TBIT, ST_RX_DATA_TBIT};
  assign bus_rx_req_byte_o = state_q inside {ST_RX_DATA, ST_SKIP, ST_RX_ADDR};
  assign bus_tx_req_bit_o  = state_q inside {ST_TX_ADDR_ACK, ST_TX_DATA_TBIT};
  assign bus_tx_req_byte_o = (state_q == ST_TX_DATA);
  assign bus_tx_sel_od_pp_o = state_q inside {ST_TX_DATA, ST_TX_DATA_TBIT};

  always_comb begin
    case (state_q)
      // ACK is driven low for our address and for 7E
      ST_TX_ADDR_ACK:  bus_tx_req_value_o = {{(BYTE_W-1){1'b0}}, ~(addr_ours | addr_rsvd)};
      ST_TX_DATA:      bus_tx_req_value_o = tx_byte_i;
      ST_TX_DATA_TBIT: bus_tx_req_value_o = {{(BYTE_W-1){1'b0}}, ~tx_last_i};
      default:         bus_tx_req_value_o = '0;
    endcase
  end

  assign done_fsm_o      = (state_q == ST_DONE);
  assign code_o          = code_q;
  assign tx_load_o       = (state_q == ST_TX_ADDR_ACK);
  assign tx_next_o       = (state_q == ST_TX_DATA) && bus_tx_done_i;
  assign rx_byte_o       = rx_q;
  assign rx_byte_valid_o = (state_q == ST_RX_DATA_TBIT) && bus_rx_done_i && !addr_rsvd;
  assign xfer_start_o    = (state_q == ST_WAIT && ccc_valid_i) ||
                           (state_q == ST_RX_ADDR && bus_rx_done_i);
  assign rstdaa_event_o  = (state_q == ST_RX_TBIT) && bus_rx_done_i && !is_direct && !has_data;

  a_rx_tx_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((bus_rx_req_bit_o || bus_rx_req_byte_o) && (bus_tx_req_bit_o || bus_tx_req_byte_o)));

endmodule

`default_nettype wire

// ==== logic/ccc_get_source.sv ====
// Direct GET response source
`timescale 1ns/1ns
`default_nettype none

module ccc_get_source (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  ccc_pkg::ccc_code_e         code_i,
  input  logic                       tx_load_i,
  input  logic                       tx_next_i,
  input  logic [ccc_pkg::LEN_W-1:0]  get_mwl_i,
  input  logic [ccc_pkg::LEN_W-1:0]  get_mrl_i,
  input  logic [ccc_pkg::BYTE_W-1:0] get_bcr_i,
  input  logic [ccc_pkg::BYTE_W-1:0] get_dcr_i,
  input  logic [ccc_pkg::PID_W-1:0]  get_pid_i,
  output logic [ccc_pkg::BYTE_W-1:0] tx_byte_o,
  output logic                       tx_last_o
);
  import ccc_pkg::*;

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_init;
  logic [CNT_W-1:0] idx;
  logic [PID_W-1:0] resp;

  // Response right aligned, byte n-1 goes out when n bytes remain
  always_comb begin
    case (code_i)
      GETBCR: begin
        cnt_init = CNT_W'(1);
        resp     = PID_W'(get_bcr_i);
      end
      GETDCR: begin
        cnt_init = CNT_W'(1);
        resp     = PID_W'(get_dcr_i);
      end
      GETMWL: begin
        cnt_init = CNT_W'(2);
        resp     = PID_W'(get_mwl_i);
      end
      GETMRL: begin
        cnt_init = CNT_W'(3);
        resp     = PID_W'({get_mrl_i, MRL_IBI_BYTE});
      end
      GETPID: begin
        cnt_init = CNT_W'(MAX_GET_BYTES);
        resp     = get_pid_i;
      end
      default: begin
        cnt_init = '0;
        resp     = '0;
      end
    endcase
  end

  // Remaining bytes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (tx_load_i) begin
      cnt_q <= cnt_init;
    end else if (tx_next_i && cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign idx       = cnt_q - 1'b1;
  assign tx_byte_o = (cnt_q == '0) ? '0 : resp[idx*BYTE_W +: BYTE_W];
  assign tx_last_o = (cnt_q == '0);

  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_next_i |-> cnt_q != '0);

endmodule

`default_nettype wire

// ==== logic/ccc_set_capture.sv ====
// SET CCC capture registers
`timescale 1ns/1ns
`default_nettype none

module ccc_set_capture (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  ccc_pkg::ccc_code_e         code_i,
  input  logic [ccc_pkg::BYTE_W-1:0] rx_byte_i,
  input  logic                       rx_byte_valid_i,
  input  logic                       xfer_start_i,
  input  logic                       rstdaa_event_i,
  output logic                       set_mwl_o,
  output logic [ccc_pkg::LEN_W-1:0]  mwl_o,
  output logic                       set_mrl_o,
  output logic [ccc_pkg::LEN_W-1:0]  mrl_o,
  output logic                       enec_ibi_o,
  output logic                       enec_crr_o,
  output logic                       enec_hj_o,
  output logic                       disec_ibi_o,
  output logic                       disec_crr_o,
  output logic                       disec_hj_o,
  output logic                       rstdaa_o
);
  import ccc_pkg::*;

  logic [1:0] idx_q;
  logic       first_byte;
  logic       second_byte;

  // Data byte index, saturates past the bytes we care about
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q <= '0;
    end else if (xfer_start_i) begin
      idx_q <= '0;
    end else if (rx_byte_valid_i && idx_q != 2'd3) begin
      idx_q <= idx_q + 1'b1;
    end
  end

  assign first_byte  = rx_byte_valid_i && (idx_q == 2'd0);
  assign second_byte = rx_byte_valid_i && (idx_q == 2'd1);

  // Max lengths arrive high byte first
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mwl_o     <= '0;
      mrl_o     <= '0;
      set_mwl_o <= 1'b0;
      set_mrl_o <= 1'b0;
    end else begin
      set_mwl_o <= 1'b0;
      set_mrl_o <= 1'b0;
      if (code_i inside {SETMWL_B, SETMWL_D}) begin
        if (first_byte) mwl_o[LEN_W-1:BYTE_W] <= rx_byte_i;
        if (second_byte) begin
          mwl_o[BYTE_W-1:0] <= rx_byte_i;
          set_mwl_o         <= 1'b1;
        end
      end
      if (code_i inside {SETMRL_B, SETMRL_D}) begin
        if (first_byte) mrl_o[LEN_W-1:BYTE_W] <= rx_byte_i;
        if (second_byte) begin
          mrl_o[BYTE_W-1:0] <= rx_byte_i;
          set_mrl_o         <= 1'b1;
        end
      end
    end
  end

  // Event bits, IBI in 0, CRR in 1, HJ in 3
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enec_ibi_o  <= 1'b0;
      enec_crr_o  <= 1'b0;
      enec_hj_o   <= 1'b0;
      disec_ibi_o <= 1'b0;
      disec_crr_o <= 1'b0;
      disec_hj_o  <= 1'b0;
    end else if (first_byte) begin
      if (code_i inside {ENEC_B, ENEC_D}) begin
        enec_ibi_o <= rx_byte_i[0];
        enec_crr_o <= rx_byte_i[1];
        enec_hj_o  <= rx_byte_i[3];
      end
      if (code_i inside {DISEC_B, DISEC_D}) begin
        disec_ibi_o <= rx_byte_i[0];
        disec_crr_o <= rx_byte_i[1];
        disec_hj_o  <= rx_byte_i[3];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rstdaa_o <= 1'b0;
    end else begin
      rstdaa_o <= rstdaa_event_i && (code_i == RSTDAA);
    end
  end

endmodule

`default_nettype wire

// ==== logic/ccc_top.sv ====
// CCC handler top level
`timescale 1ns/1ns
`default_nettype none

module ccc_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  ccc_pkg::ccc_code_e         ccc_i,
  input  logic                       ccc_valid_i,
  input  logic                       bus_rstart_det_i,
  input  logic                       bus_stop_det_i,
  input  logic [ccc_pkg::BYTE_W-1:0] bus_rx_data_i,
  input  logic                       bus_rx_done_i,
  input  logic                       bus_tx_done_i,
  input  logic [ccc_pkg::ADDR_W-1:0] target_sta_address_i,
  input  logic                       target_sta_address_valid_i,
  input  logic [ccc_pkg::ADDR_W-1:0] target_dyn_address_i,
  input  logic                       target_dyn_address_valid_i,
  input  logic [ccc_pkg::LEN_W-1:0]  get_mwl_i,
  input  logic [ccc_pkg::LEN_W-1:0]  get_mrl_i,
  input  logic [ccc_pkg::BYTE_W-1:0] get_bcr_i,
  input  logic [ccc_pkg::BYTE_W-1:0] get_dcr_i,
  input  logic [ccc_pkg::PID_W-1:0]  get_pid_i,
  output logic                       done_fsm_o,
  output logic                       bus_rx_req_bit_o,
  output logic                       bus_rx_req_byte_o,
  output logic                       bus_tx_req_bit_o,
  output logic                       bus_tx_req_byte_o,
  output logic [ccc_pkg::BYTE_W-1:0] bus_tx_req_value_o,
  output logic                       bus_tx_sel_od_pp_o,
  output logic                       set_mwl_o,
  output logic [ccc_pkg::LEN_W-1:0]  mwl_o,
  output logic                       set_mrl_o,
  output logic [ccc_pkg::LEN_W-1:0]  mrl_o,
  output logic                       enec_ibi_o,
  output logic                       enec_crr_o,
  output logic                       enec_hj_o,
  output logic                       disec_ibi_o,
  output logic                       disec_crr_o,
  output logic                       disec_hj_o,
  output logic                       rstdaa_o
);
  import ccc_pkg::*;

  ccc_code_e         code;
  logic              tx_load;
  logic              tx_next;
  logic [BYTE_W-1:0] tx_byte;
  logic              tx_last;
  logic [BYTE_W-1:0] rx_byte;
  logic              rx_byte_valid;
  logic              xfer_start;
  logic              rstdaa_event;

  ccc_fsm u_fsm (
    .clk_i,
    .rst_ni,
    .ccc_i,
    .ccc_valid_i,
    .bus_rstart_det_i,
    .bus_stop_det_i,
    .bus_rx_data_i,
    .bus_rx_done_i,
    .bus_tx_done_i,
    .target_sta_address_i,
    .target_sta_address_valid_i,
    .target_dyn_address_i,
    .target_dyn_address_valid_i,
    .tx_byte_i          (tx_byte),
    .tx_last_i          (tx_last),
    .done_fsm_o,
    .bus_rx_req_bit_o,
    .bus_rx_req_byte_o,
    .bus_tx_req_bit_o,
    .bus_tx_req_byte_o,
    .bus_tx_req_value_o,
    .bus_tx_sel_od_pp_o,
    .code_o             (code),
    .tx_load_o          (tx_load),
    .tx_next_o          (tx_next),
    .rx_byte_o          (rx_byte),
    .rx_byte_valid_o    (rx_byte_valid),
    .xfer_start_o       (xfer_start),
    .rstdaa_event_o     (rstdaa_event)
  );

  ccc_get_source u_get_source (
    .clk_i,
    .rst_ni,
    .code_i    (code),
    .tx_load_i (tx_load),
    .tx_next_i (tx_next),
    .get_mwl_i,
    .get_mrl_i,
    .get_bcr_i,
    .get_dcr_i,
    .get_pid_i,
    .tx_byte_o (tx_byte),
    .tx_last_o (tx_last)
  );

  ccc_set_capture u_set_capture (
    .clk_i,
    .rst_ni,
    .code_i          (code),
    .rx_byte_i       (rx_byte),
    .rx_byte_valid_i (rx_byte_valid),
    .xfer_start_i    (xfer_start),
    .rstdaa_event_i  (rstdaa_event),
    .set_mwl_o,
    .mwl_o,
    .set_mrl_o,
    .mrl_o,
    .enec_ibi_o,
    .enec_crr_o,
    .enec_hj_o,
    .disec_ibi_o,
    .disec_crr_o,
    .disec_hj_o,
    .rstdaa_o
  );

endmodule

`default_nettype wire

// ==== test/ccc_tb.sv ====
// CCC handler testbench
`timescale 1ns/1ns
`default_nettype none

module ccc_tb;
  import ccc_pkg::*;

  localparam int         TIMEOUT_CYCLES = 100;
  localparam logic [3:0] REQ_RX_BYTE    = 4'b0001;
  localparam logic [3:0] REQ_RX_BIT     = 4'b0010;
  localparam logic [3:0] REQ_TX_BYTE    = 4'b0100;
  localparam logic [3:0] REQ_TX_BIT     = 4'b1000;

  logic              clk_i = 1'b0;
  logic              rst_ni;
  ccc_code_e         ccc_i;
  logic              ccc_valid_i;
  logic              bus_rstart_det_i;
  logic              bus_stop_det_i;
  logic [BYTE_W-1:0] bus_rx_data_i;
  logic              bus_rx_done_i;
  logic              bus_tx_done_i;
  logic [ADDR_W-1:0] target_sta_address_i;
  logic              target_sta_address_valid_i;
  logic [ADDR_W-1:0] target_dyn_address_i;
  logic              target_dyn_address_valid_i;
  logic [LEN_W-1:0]  get_mwl_i;
  logic [LEN_W-1:0]  get_mrl_i;
  logic [BYTE_W-1:0] get_bcr_i;
  logic [BYTE_W-1:0] get_dcr_i;
  logic [PID_W-1:0]  get_pid_i;
  logic              done_fsm_o;
  logic              bus_rx_req_bit_o;
  logic              bus_rx_req_byte_o;
  logic              bus_tx_req_bit_o;
  logic              bus_tx_req_byte_o;
  logic [BYTE_W-1:0] bus_tx_req_value_o;
  logic              bus_tx_sel_od_pp_o;
  logic              set_mwl_o;
  logic [LEN_W-1:0]  mwl_o;
  logic              set_mrl_o;
  logic [LEN_W-1:0]  mrl_o;
  logic              enec_ibi_o;
  logic              enec_crr_o;
  logic              enec_hj_o;
  logic              disec_ibi_o;
  logic              disec_crr_o;
  logic              disec_hj_o;
  logic              rstdaa_o;

  // Fields of the current golden line
  int          fd;
  int          fields;
  string       line;
  logic [7:0]  kind;
  logic [7:0]  code;
  logic [7:0]  addr_b;
  int          n;
  logic [7:0]  d [6];
  logic        ack;

  // Expected register state
  logic [15:0] exp_mwl = '0;
  logic [15:0] exp_mrl = '0;
  logic [2:0]  exp_enec = '0;
  logic [2:0]  exp_disec = '0;

  int          seed = 32'h09d15759;
  int          mwl_pulses = 0;
  int          mrl_pulses = 0;
  int          rstdaa_pulses = 0;
  int          done_pulses = 0;

  ccc_top dut0 (.*);

  always #50 clk_i = ~clk_i;

  always @(negedge clk_i) begin
    if (set_mwl_o) mwl_pulses++;
    if (set_mrl_o) mrl_pulses++;
    if (rstdaa_o) rstdaa_pulses++;
    if (done_fsm_o) done_pulses++;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("error: time %0t, %s = %0h, expected %0h", $time, name, got, exp);
      $display("test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s at time %0t", what, $time);
    $display("test failed");
    $fatal(1, "run aborted");
  endtask

  function automatic logic [3:0] req_now();
    return {bus_tx_req_bit_o, bus_tx_req_byte_o, bus_rx_req_bit_o, bus_rx_req_byte_o};
  endfunction

  task automatic wait_request(input logic [3:0] want);
    int t;
    for (t = 0; t < TIMEOUT_CYCLES; t++) begin
      @(negedge clk_i);
      if (req_now() != 4'b0000) break;
    end
    if (req_now() == 4'b0000) begin
      abort_run("timeout waiting for a bus request");
    end else if (req_now() != want) begin
      check_value("bus requests", 32'(req_now()), 32'(want));
    end
  endtask

  // PHY model, answers a request after 0 to 3 cycles
  task automatic serve(input logic [3:0] want, input logic [7:0] rx_data,
                       output logic [7:0] value, output logic od_pp);
    int delay;
    wait_request(want);
    value = bus_tx_req_value_o;
    od_pp = bus_tx_sel_od_pp_o;
    delay = $random(seed) & 3;
    repeat (delay) @(posedge clk_i);
    @(posedge clk_i);
    if (want == REQ_RX_BYTE || want == REQ_RX_BIT) begin
      bus_rx_done_i <= 1'b1;
      bus_rx_data_i <= rx_data;
    end else begin
      bus_tx_done_i <= 1'b1;
    end
    @(posedge clk_i);
    bus_rx_done_i <= 1'b0;
    bus_tx_done_i <= 1'b0;
  endtask

  task automatic expect_quiet();
    repeat (4) begin
      @(negedge clk_i);
      check_value("bus requests", 32'(req_now()), 0);
    end
  endtask

  // done_fsm_o must follow STOP by exactly one cycle
  task automatic send_stop();
    @(posedge clk_i);
    bus_stop_det_i <= 1'b1;
    @(negedge clk_i);
    check_value("done_fsm_o", 32'(done_fsm_o), 0);
    @(posedge clk_i);
    bus_stop_det_i <= 1'b0;
    @(negedge clk_i);
    check_value("done_fsm_o", 32'(done_fsm_o), 1);
    @(negedge clk_i);
    check_value("done_fsm_o", 32'(done_fsm_o), 0);
  endtask

  task automatic apply_config();
    logic [6:0]  sta;
    logic        sta_v;
    logic [6:0]  dyn;
    logic        dyn_v;
    logic [7:0]  bcr;
    logic [7:0]  dcr;
    logic [15:0] mwl;
    logic [15:0] mrl;
    logic [47:0] pid;
    fields = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h",
                     kind, sta, sta_v, dyn, dyn_v, bcr, dcr, mwl, mrl, pid);
    if (fields != 10) begin
      abort_run("malformed config line in golden file");
    end else begin
      @(posedge clk_i);
      target_sta_address_i       <= sta;
      target_sta_address_valid_i <= sta_v;
      target_dyn_address_i       <= dyn;
      target_dyn_address_valid_i <= dyn_v;
      get_bcr_i                  <= bcr;
      get_dcr_i                  <= dcr;
      get_mwl_i                  <= mwl;
      get_mrl_i                  <= mrl;
      get_pid_i                  <= pid;
    end
  endtask

  task automatic run_transaction();
    logic [7:0] value;
    logic       od_pp;
    logic       rsvd;
    logic       get;
    logic       data_phase;
    int         i;
    int         base_mwl;
    int         base_mrl;
    int         base_rst;
    int         base_done;
    base_mwl   = mwl_pulses;
    base_mrl   = mrl_pulses;
    base_rst   = rstdaa_pulses;
    base_done  = done_pulses;
    rsvd       = (kind == "D") && (addr_b[7:1] == 7'h7E);
    get        = code inside {8'h8B, 8'h8C, 8'h8D, 8'h8E, 8'h8F};
    data_phase = (kind == "B") || (!rsvd && !ack && !get);
    @(posedge clk_i);
    ccc_i       <= ccc_code_e'(code);
    ccc_valid_i <= 1'b1;
    @(posedge clk_i);
    ccc_valid_i <= 1'b0;
    // T-bit of the command code byte
    serve(REQ_RX_BIT, {7'b0, ~^code}, value, od_pp);
    if (kind == "D") begin
      wait_request(REQ_RX_BYTE);
      @(posedge clk_i);
      bus_rstart_det_i <= 1'b1;
      @(posedge clk_i);
      bus_rstart_det_i <= 1'b0;
      serve(REQ_RX_BYTE, addr_b, value, od_pp);
      serve(REQ_TX_BIT, 8'h00, value, od_pp);
      check_value("ack bit", 32'(value[0]), 32'(ack));
      check_value("ack od_pp", 32'(od_pp), 0);
      if (!rsvd && !ack && get) begin
        for (i = 0; i < n; i++) begin
          serve(REQ_TX_BYTE, 8'h00, value, od_pp);
          check_value("tx byte", 32'(value), 32'(d[i]));
          check_value("tx od_pp", 32'(od_pp), 1);
          serve(REQ_TX_BIT, 8'h00, value, od_pp);
          check_value("tx T-bit", 32'(value[0]), 32'(i != n - 1));
        end
      end
    end
    if (data_phase) begin
      for (i = 0; i < n; i++) begin
        serve(REQ_RX_BYTE, d[i], value, od_pp);
        serve(REQ_RX_BIT, {7'b0, ~^d[i]}, value, od_pp);
      end
    end
    if (!(data_phase && n > 0)) expect_quiet();
    send_stop();
    if (data_phase) begin
      case (code)
        8'h09, 8'h89: exp_mwl = {d[0], d[1]};
        8'h0A, 8'h8A: exp_mrl = {d[0], d[1]};
        8'h00, 8'h80: exp_enec = {d[0][3], d[0][1], d[0][0]};
        8'h01, 8'h81: exp_disec = {d[0][3], d[0][1], d[0][0]};
        default: ;
      endcase
    end
    check_value("set_mwl_o pulses", mwl_pulses - base_mwl,
                32'(data_phase && (code == 8'h09 || code == 8'h89)));
    check_value("set_mrl_o pulses", mrl_pulses - base_mrl,
                32'(data_phase && (code == 8'h0A || code == 8'h8A)));
    check_value("rstdaa_o pulses", rstdaa_pulses - base_rst,
                32'(kind == "B" && code == 8'h06));
    check_value("done_fsm_o pulses", done_pulses - base_done, 1);
    check_value("mwl_o", 32'(mwl_o), 32'(exp_mwl));
    check_value("mrl_o", 32'(mrl_o), 32'(exp_mrl));
    check_value("enec bits", 32'({enec_hj_o, enec_crr_o, enec_ibi_o}), 32'(exp_enec));
    check_value("disec bits", 32'({disec_hj_o, disec_crr_o, disec_ibi_o}), 32'(exp_disec));
  endtask

  initial begin
    rst_ni                     = 1'b0;
    ccc_i                      = ENEC_B;
    ccc_valid_i                = 1'b0;
    bus_rstart_det_i           = 1'b0;
    bus_stop_det_i             = 1'b0;
    bus_rx_data_i              = '0;
    bus_rx_done_i              = 1'b0;
    bus_tx_done_i              = 1'b0;
    target_sta_address_i       = '0;
    target_sta_address_valid_i = 1'b0;
    target_dyn_address_i       = '0;
    target_dyn_address_valid_i = 1'b0;
    get_mwl_i                  = '0;
    get_mrl_i                  = '0;
    get_bcr_i                  = '0;
    get_dcr_i                  = '0;
    get_pid_i                  = '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_value("bus requests", 32'(req_now()), 0);
    check_value("done_fsm_o", 32'(done_fsm_o), 0);
    check_value("set_mwl_o", 32'(set_mwl_o), 0);
    check_value("set_mrl_o", 32'(set_mrl_o), 0);
    check_value("rstdaa_o", 32'(rstdaa_o), 0);
    check_value("mwl_o", 32'(mwl_o), 0);
    check_value("mrl_o", 32'(mrl_o), 0);
    @(posedge clk_i);
    fd = $fopen("test/ccc_golden.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open test/ccc_golden.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line.getc(0) == "#") continue;
        if (line.getc(0) == "C") begin
          apply_config();
        end else begin
          fields = $sscanf(line, "%c %h %h %d %h %h %h %h %h %h %h",
                           kind, code, addr_b, n, d[0], d[1], d[2], d[3], d[4], d[5], ack);
          if (fields != 11) begin
            abort_run("malformed transaction line in golden file");
          end else begin
            run_transaction();
          end
        end
      end
      $fclose(fd);
      $display("test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== test/ccc_golden.txt ====
# C sta_addr sta_valid dyn_addr dyn_valid bcr dcr mwl mrl pid
# B|D code addr_byte n d0 d1 d2 d3 d4 d5 ack (data written for SET, expected for GET)
C 2A 1 31 0 A6 C4 0100 0200 0A1B2C3D4E5F
B 09 00 2 12 34 00 00 00 00 0
B 0A 00 2 56 78 00 00 00 00 0
B 00 00 1 0B 00 00 00 00 00 0
B 01 00 1 0A 00 00 00 00 00 0
B 06 00 0 00 00 00 00 00 00 0
D 8E 55 1 A6 00 00 00 00 00 0
D 8F 55 1 C4 00 00 00 00 00 0
D 8B 55 2 01 00 00 00 00 00 0
D 8C 55 3 02 00 FF 00 00 00 0
D 8D 55 6 0A 1B 2C 3D 4E 5F 0
D 89 54 2 AB CD 00 00 00 00 0
D 8A 54 2 9A BC 00 00 00 00 0
D 80 54 1 08 00 00 00 00 00 0
D 81 54 1 03 00 00 00 00 00 0
D 89 20 2 11 22 00 00 00 00 1
D 8E 21 1 00 00 00 00 00 00 1
D 8D FD 0 00 00 00 00 00 00 0
D 89 FC 2 11 22 00 00 00 00 0
C 2A 1 31 1 5A 3C 0400 0800 112233445566
D 8E 63 1 5A 00 00 00 00 00 0
D 8E 55 1 00 00 00 00 00 00 1
D 8B 63 2 04 00 00 00 00 00 0
D 8C 63 3 08 00 FF 00 00 00 0
D 8D 63 6 11 22 33 44 55 66 0
D 8A 62 2 0F F0 00 00 00 00 0
B 00 00 1 F4 00 00 00 00 00 0
B 01 00 1 F7 00 00 00 00 00 0
B 06 00 0 00 00 00 00 00 00 0
B 09 00 2 FF EE 00 00 00 00 0

// ==== verilog.f ====
logic/ccc_pkg.sv
logic/ccc_fsm.sv
logic/ccc_get_source.sv
logic/ccc_set_capture.sv
logic/ccc_top.sv
test/ccc_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --assert -j 0
TOP      := ccc_tb
FILELIST := verilog.f
OBJ_DIR  := obj_dir

BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(FILELIST) $(SRCS)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
